//--- Bender.yml
package:
  name: code_lock

sources:
  - design/lock_pkg.sv
  - design/key_decoder.sv
  - design/code_entry.sv
  - design/lock_controller.sv
  - design/alert_tone.sv
  - design/code_lock_top.sv
  - target: simulation
    files:
      - verification/code_lock_tb.sv

//--- all.f
design/lock_pkg.sv
design/key_decoder.sv
design/code_entry.sv
design/lock_controller.sv
design/alert_tone.sv
design/code_lock_top.sv
verification/code_lock_tb.sv

//--- design/alert_tone.sv
`default_nettype none

module alert_tone import lock_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire tone_req_t  tone_req,
    output logic            buzzer
);

    logic        active_q;
    tone_kind_e  kind_q;
    logic [15:0] dur_q;   // cycles since the request
    logic [15:0] half_q;  // cycles in the current half period
    logic [15:0] half_sel;
    logic [15:0] len_sel;
    logic        in_gap;

    always_comb begin
        case (kind_q)
            TONE_PASS: begin
                half_sel = PASS_HALF;
                len_sel  = PASS_LEN;
            end
            TONE_FAIL: begin
                half_sel = FAIL_HALF;
                len_sel  = FAIL_LEN;
            end
            default: begin
                half_sel = CLICK_HALF;
                len_sel  = CLICK_LEN;
            end
        endcase
        // fail tone goes silent in the middle of its pattern
        in_gap = (kind_q == TONE_FAIL)
              && (dur_q >= (FAIL_GAP_START - 16'd1)) // judged for the next cycle
              && (dur_q < (FAIL_GAP_END - 16'd1));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            kind_q   <= TONE_CLICK;
            dur_q    <= 16'd0;
            half_q   <= 16'd0;
            buzzer   <= 1'b0;
        end else if (tone_req.valid) begin // restart on any request
            active_q <= 1'b1;
            kind_q   <= tone_req.kind;
            dur_q    <= 16'd0;
            half_q   <= 16'd0;
            buzzer   <= 1'b1;
        end else if (active_q) begin
            dur_q <= dur_q + 16'd1;
            if (dur_q == (len_sel - 16'd1)) begin
                active_q <= 1'b0;
                buzzer   <= 1'b0;
            end else if (in_gap) begin
                half_q <= 16'd0;
                buzzer <= 1'b0;
            end else if (half_q == (half_sel - 16'd1)) begin
                half_q <= 16'd0;
                buzzer <= ~buzzer;
            end else begin
                half_q <= half_q + 16'd1;
            end
        end
    end

    a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !active_q |-> !buzzer);

endmodule

`default_nettype wire

//--- design/code_entry.sv
`default_nettype none

module code_entry import lock_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire key_evt_t   key_evt,
    input  wire             reject_clear,
    input  wire             lockout,
    output logic     [11:0] digits,
    output logic            complete
);

    logic [1:0] count_q;  // number of digits held
    logic       do_clear;
    logic       do_shift;

    always_comb begin
        do_clear = reject_clear
                || (key_evt.valid && (key_evt.kind == KEY_CLEAR))
                || (key_evt.valid && (key_evt.kind == KEY_CLEAR_ALL));
        do_shift = key_evt.valid
                && (key_evt.kind == KEY_DIGIT)
                && !lockout
                && (count_q < CODE_DIGITS);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits  <= {3{DIGIT_BLANK}};
            count_q <= 2'd0;
        end else if (do_clear) begin
            digits  <= {3{DIGIT_BLANK}};
            count_q <= 2'd0;
        end else if (do_shift) begin
            digits  <= {digits[7:0], key_evt.digit}; // new digit enters on the right
            count_q <= count_q + 2'd1;
        end
    end

    always_comb begin
        complete = (count_q == CODE_DIGITS);
    end

    // a full entry never shows an empty position
    a_complete_filled: assert property (@(posedge clk) disable iff (!rst_n)
        complete |-> ((digits[11:8] != DIGIT_BLANK)
                   && (digits[7:4] != DIGIT_BLANK)
                   && (digits[3:0] != DIGIT_BLANK)));

endmodule

`default_nettype wire

//--- design/code_lock_top.sv
`default_nettype none

module code_lock_top import lock_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] onehot,
    output logic [11:0] display,
    output logic        unlocked,
    output logic        locked_out,
    output logic  [2:0] tries,
    output logic        buzzer
);

    key_evt_t    key_evt;
    tone_req_t   tone_req;
    logic [11:0] digits;
    logic        complete;
    logic        reject_clear;

    key_decoder u_key_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .onehot  (onehot),
        .key_evt (key_evt)
    );

    code_entry u_code_entry (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_evt      (key_evt),
        .reject_clear (reject_clear),
        .lockout      (locked_out), // blocks digit keys
        .digits       (digits),
        .complete     (complete)
    );

    lock_controller u_lock_controller (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_evt      (key_evt),
        .digits       (digits),
        .complete     (complete),
        .lockout      (locked_out),
        .reject_clear (reject_clear),
        .tone_req     (tone_req),
        .tries        (tries),
        .unlocked     (unlocked),
        .display      (display)
    );

    alert_tone u_alert_tone (
        .clk      (clk),
        .rst_n    (rst_n),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

//--- design/key_decoder.sv
`default_nettype none

module key_decoder import lock_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire      [15:0] onehot,
    output key_evt_t        key_evt
);

    logic [15:0] sample_q; // onehot at the last edge
    logic [15:0] prev_q;   // onehot one edge before that
    key_evt_t    decoded;

    function automatic key_evt_t decode_key(input logic [15:0] lines);
        key_evt_t evt;
        evt = '0;
        if (lines == (16'h1 << KEY_BIT_ENTER)) begin
            evt.valid = 1'b1;
            evt.kind  = KEY_ENTER;
        end else if (lines == (16'h1 << KEY_BIT_CLEAR)) begin
            evt.valid = 1'b1;
            evt.kind  = KEY_CLEAR;
        end else if (lines == (16'h1 << KEY_BIT_CLEAR_ALL)) begin
            evt.valid = 1'b1;
            evt.kind  = KEY_CLEAR_ALL;
        end else begin
            for (int d = 0; d < KEY_DIGIT_COUNT; d++) begin
                if (lines == (16'h1 << KEY_BIT_DIGIT[d])) begin
                    evt.valid = 1'b1;
                    evt.kind  = KEY_DIGIT;
                    evt.digit = 4'(d);
                end
            end
        end
        return evt; // zero lines or several set bits stay invalid
    endfunction

    always_comb begin
        decoded = decode_key(sample_q);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_q <= '0;
            prev_q   <= '0;
            key_evt  <= '0;
        end else begin
            sample_q <= onehot;
            prev_q   <= sample_q;
            key_evt  <= (sample_q != prev_q) ? decoded : '0; // only on a change
        end
    end

    a_evt_on_change: assert property (@(posedge clk) disable iff (!rst_n)
        key_evt.valid |-> ($past(sample_q) != $past(prev_q)));

endmodule

`default_nettype wire

//--- design/lock_controller.sv
`default_nettype none

module lock_controller import lock_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire key_evt_t   key_evt,
    input  wire      [11:0] digits,
    input  wire             complete,
    output logic            lockout,
    output logic            reject_clear,
    output tone_req_t       tone_req,
    output logic      [2:0] tries,
    output logic            unlocked,
    output logic     [11:0] display
);

    logic code_match;

    always_comb begin
        code_match = (digits == SECRET_CODE);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lockout      <= 1'b0;
            reject_clear <= 1'b0;
            tone_req     <= '0;
            tries        <= 3'd0;
            unlocked     <= 1'b0;
        end else begin
            reject_clear <= 1'b0; // strobes by default
            tone_req     <= '0;
            if (key_evt.valid && lockout) begin
                if (key_evt.kind == KEY_CLEAR_ALL) begin // only way out
                    lockout  <= 1'b0;
                    tries    <= 3'd0;
                    tone_req <= '{valid: 1'b1, kind: TONE_CLICK};
                end
            end else if (key_evt.valid) begin
                tone_req <= '{valid: 1'b1, kind: TONE_CLICK};
                case (key_evt.kind)
                    KEY_ENTER: begin
                        if (complete && !unlocked && code_match) begin
                            unlocked <= 1'b1;
                            tone_req <= '{valid: 1'b1, kind: TONE_PASS};
                        end else if (complete && !unlocked) begin
                            reject_clear <= 1'b1;
                            tries        <= tries + 3'd1;
                            tone_req     <= '{valid: 1'b1, kind: TONE_FAIL};
                            if (tries == (MAX_TRIES - 3'd1)) begin
                                lockout <= 1'b1; // this failure is the last allowed
                            end
                        end
                    end
                    KEY_CLEAR: begin
                        unlocked <= 1'b0;
                    end
                    KEY_CLEAR_ALL: begin
                        unlocked <= 1'b0;
                        tries    <= 3'd0;
                    end
                    default: ; // digits only click
                endcase
            end
        end
    end

    always_comb begin
        if (lockout) begin
            display = DISP_LOCKOUT;
        end else if (unlocked) begin
            display = DISP_PASS;
        end else begin
            display = digits;
        end
    end

    a_state_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(unlocked && lockout));

endmodule

`default_nettype wire

//--- design/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef enum logic [1:0] {
        KEY_DIGIT     = 2'd0,
        KEY_ENTER     = 2'd1,
        KEY_CLEAR     = 2'd2,
        KEY_CLEAR_ALL = 2'd3
    } key_kind_e;

    typedef enum logic [1:0] {
        TONE_CLICK = 2'd0,
        TONE_PASS  = 2'd1,
        TONE_FAIL  = 2'd2
    } tone_kind_e;

    typedef struct packed {
        logic      valid;
        key_kind_e kind;
        logic [3:0] digit; // bcd, only meaningful for KEY_DIGIT
    } key_evt_t;

    typedef struct packed {
        logic       valid;
        tone_kind_e kind;
    } tone_req_t;

    // one-hot bit positions of the keypad lines
    localparam int unsigned KEY_BIT_ENTER     = 0;
    localparam int unsigned KEY_BIT_CLEAR     = 12;
    localparam int unsigned KEY_BIT_CLEAR_ALL = 8;
    localparam int unsigned KEY_DIGIT_COUNT   = 10;
    localparam int unsigned KEY_BIT_DIGIT [KEY_DIGIT_COUNT] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};

    localparam int unsigned CODE_DIGITS  = 3;
    localparam logic [11:0] SECRET_CODE  = 12'h246; // msd first
    localparam logic [3:0]  DIGIT_BLANK  = 4'hF;
    localparam logic [11:0] DISP_PASS    = 12'hBCC;
    localparam logic [11:0] DISP_LOCKOUT = 12'h000;
    localparam logic [2:0]  MAX_TRIES    = 3'd6;

    // tone timing in clock cycles, sized for simulation
    localparam logic [15:0] CLICK_HALF     = 16'd4;
    localparam logic [15:0] CLICK_LEN      = 16'd64;
    localparam logic [15:0] PASS_HALF      = 16'd2;
    localparam logic [15:0] PASS_LEN       = 16'd192;
    localparam logic [15:0] FAIL_HALF      = 16'd8;
    localparam logic [15:0] FAIL_LEN       = 16'd288;
    localparam logic [15:0] FAIL_GAP_START = 16'd96;
    localparam logic [15:0] FAIL_GAP_END   = 16'd192;

endpackage

`default_nettype wire

//--- verification/code_lock_tb.sv
`default_nettype none

module code_lock_tb import lock_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [11:0] digits;
        logic [1:0]  count;
        logic        unlocked;
        logic        lockout;
        logic [2:0]  tries;
        logic        tone;     // press should start a tone
    } model_t;

    logic        clk;
    logic        rst_n;
    logic [15:0] onehot;
    logic [11:0] display;
    logic        unlocked;
    logic        locked_out;
    logic [2:0]  tries;
    logic        buzzer;

    model_t      exp;
    logic        check_req;
    int          errors;
    int          checks;
    int          cyc;
    int          last_change;
    logic        buz_last;
    int          intervals[$]; // cycles between buzzer changes

    code_lock_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .onehot     (onehot),
        .display    (display),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .tries      (tries),
        .buzzer     (buzzer)
    );

    always #5 clk = ~clk;

    // applies one keypad pattern to the expected state
    function automatic model_t model_key(input model_t s, input logic [15:0] lines);
        model_t n;
        int     d;
        n = s;
        d = -1;
        n.tone = 1'b0;
        for (int i = 0; i < KEY_DIGIT_COUNT; i++) begin
            if (lines == (16'h1 << KEY_BIT_DIGIT[i])) d = i;
        end
        if (lines == (16'h1 << KEY_BIT_CLEAR_ALL)) begin
            n = '{digits: 12'hFFF, count: 2'd0, unlocked: 1'b0, lockout: 1'b0,
                  tries: 3'd0, tone: 1'b1};
        end else if (lines == (16'h1 << KEY_BIT_CLEAR)) begin
            n.digits   = 12'hFFF;
            n.count    = 2'd0;
            n.unlocked = 1'b0;
            n.tone     = !s.lockout;
        end else if (lines == (16'h1 << KEY_BIT_ENTER)) begin
            n.tone = !s.lockout;
            if (!s.lockout && !s.unlocked && (s.count == 2'd3)) begin
                if (s.digits == SECRET_CODE) begin
                    n.unlocked = 1'b1;
                end else begin
                    n.digits  = 12'hFFF;
                    n.count   = 2'd0;
                    n.tries   = s.tries + 3'd1;
                    n.lockout = (n.tries == MAX_TRIES);
                end
            end
        end else if (d >= 0 && !s.lockout) begin
            n.tone = 1'b1;
            if (s.count < 2'd3) begin
                n.digits = {s.digits[7:0], 4'(d)};
                n.count  = s.count + 2'd1;
            end
        end
        return n;
    endfunction

    always @(negedge clk) begin // buzzer edge recorder
        cyc = cyc + 1;
        if (buzzer !== buz_last) begin
            intervals.push_back(cyc - last_change);
            last_change = cyc;
            buz_last    = buzzer;
        end
    end

    always @(negedge clk) begin
        if (check_req) begin
            logic [11:0] exp_disp;
            exp_disp = exp.lockout ? DISP_LOCKOUT : (exp.unlocked ? DISP_PASS : exp.digits);
            checks = checks + 1;
            assert (display === exp_disp) else begin
                errors++;
                $display("Error display: got %h, expected %h", display, exp_disp);
            end
            assert (unlocked === exp.unlocked) else begin
                errors++;
                $display("Error unlocked: got %h, expected %h", unlocked, exp.unlocked);
            end
            assert (locked_out === exp.lockout) else begin
                errors++;
                $display("Error locked_out: got %h, expected %h", locked_out, exp.lockout);
            end
            assert (tries === exp.tries) else begin
                errors++;
                $display("Error tries: got %h, expected %h", tries, exp.tries);
            end
            assert ((intervals.size() != 0) == exp.tone) else begin
                errors++;
                $display("Error buzzer activity: got %h, expected %h",
                         (intervals.size() != 0), exp.tone);
            end
            check_req = 1'b0;
        end
    end

    task automatic wait_quiet();
        int n;
        int quiet;
        quiet = 0;
        for (n = 0; n < 2000 && quiet < 120; n++) begin // longer than the fail gap
            @(negedge clk);
            quiet = buzzer ? 0 : quiet + 1;
        end
        if (quiet < 120) begin
            errors++;
            $display("buzzer did not go quiet within 2000 cycles");
        end
    endtask

    task automatic request_check();
        int n;
        @(posedge clk);
        check_req = 1'b1;
        for (n = 0; n < 8 && check_req; n++) @(posedge clk);
        if (check_req) begin
            errors++;
            $display("output comparison did not run in time");
        end
    endtask

    task automatic press_key(input logic [15:0] lines);
        intervals.delete();
        @(posedge clk);
        onehot <= lines;
        repeat (4) @(posedge clk);
        onehot <= '0;
        repeat (4) @(posedge clk);
        wait_quiet();
        exp = model_key(exp, lines);
        request_check();
    endtask

    task automatic press_digit(input int d);
        press_key(16'h1 << KEY_BIT_DIGIT[d]);
    endtask

    task automatic enter_code(input int d2, input int d1, input int d0);
        press_digit(d2);
        press_digit(d1);
        press_digit(d0);
        press_key(16'h1 << KEY_BIT_ENTER);
    endtask

    task automatic check_tone(input int half, input logic want_gap);
        int longest;
        longest = 0;
        assert (intervals.size() > 1) else begin
            errors++;
            $display("buzzer did not toggle after the request");
        end
        for (int i = 1; i < intervals.size(); i++) begin // first entry is from idle
            if (intervals[i] > longest) longest = intervals[i];
            if (!want_gap || intervals[i] < int'(FAIL_GAP_END - FAIL_GAP_START)) begin
                assert (intervals[i] == half) else begin
                    errors++;
                    $display("Error buzzer half period: got %h, expected %h", intervals[i], half);
                end
            end
        end
        if (want_gap) begin
            assert (longest >= int'(FAIL_GAP_END - FAIL_GAP_START)) else begin
                errors++;
                $display("Error buzzer gap: got %h, expected at least %h",
                         longest, FAIL_GAP_END - FAIL_GAP_START);
            end
        end
    endtask

    initial begin
        int r;
        int d;
        void'($urandom(32'h7c1d1c9d));
        clk       = 1'b0;
        rst_n     = 1'b0;
        onehot    = '0;
        check_req = 1'b0;
        errors    = 0;
        checks    = 0;
        cyc       = 0;
        last_change = 0;
        buz_last  = 1'b0;
        exp = '{digits: 12'hFFF, count: 2'd0, unlocked: 1'b0, lockout: 1'b0, tries: 3'd0,
                tone: 1'b0};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait_quiet();
        request_check(); // reset state with a silent buzzer

        for (int i = 1; i <= 4; i++) press_digit(i); // fourth digit ignored
        press_key(16'h1 << KEY_BIT_CLEAR);

        enter_code(2, 4, 6);
        check_tone(PASS_HALF, 1'b0);
        press_key(16'h1 << KEY_BIT_CLEAR_ALL);

        for (int i = 0; i < 6; i++) begin
            d = $urandom_range(0, 9);
            enter_code((d == 2) ? 3 : d, $urandom_range(0, 9), $urandom_range(0, 9));
            check_tone(FAIL_HALF, 1'b1);
        end
        press_digit(5); // locked out so no tone expected
        press_key(16'h1 << KEY_BIT_CLEAR_ALL);

        for (int i = 0; i < 300; i++) begin
            r = $urandom_range(0, 15);
            if (r < 12) begin
                press_key(16'h1 << $urandom_range(0, 15));
            end else if (r < 14) begin
                press_key(16'($urandom)); // mostly several bits set
            end else if (r == 14) begin
                enter_code(2, 4, 6);
            end else begin
                press_key(16'h1 << KEY_BIT_CLEAR_ALL);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
